// File: keypadPkg.sv
// keypad shared constants
package keypadPkg;

    // matrix size
    localparam int ROWS = 4;
    localparam int COLS = 4;
    localparam int ROW_BITS = $clog2(ROWS);
    localparam int COL_BITS = $clog2(COLS);

    // cycles per row before the columns are sampled, covers the synchronizer
    localparam int ROW_DWELL = 4;
    localparam int DWELL_BITS = $clog2(ROW_DWELL);

    // stable cycles before a press counts
    localparam int DEBOUNCE_CYCLES = 10;
    localparam int DEBOUNCE_BITS = $clog2(DEBOUNCE_CYCLES + 1);

    // each digit lit for 2**REFRESH_EXP cycles
    localparam int REFRESH_EXP = 8;

    typedef logic [3:0] keyCode;

    // g at bit 6 down to a at bit 0
    typedef logic [6:0] segments;

    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(ROWS - 1);
    localparam logic [DWELL_BITS-1:0] DWELL_LAST = DWELL_BITS'(ROW_DWELL - 1);
    localparam logic [DEBOUNCE_BITS-1:0] DEBOUNCE_LAST = DEBOUNCE_BITS'(DEBOUNCE_CYCLES - 1);

    // physical key positions, [row][column]
    localparam keyCode KEY_MAP [ROWS][COLS] = '{
        '{4'hA, 4'h0, 4'hB, 4'hF},
        '{4'h7, 4'h8, 4'h9, 4'hE},
        '{4'h4, 4'h5, 4'h6, 4'hD},
        '{4'h1, 4'h2, 4'h3, 4'hC}
    };

    // active-high hex patterns, the display inverts them
    localparam segments SEG_TABLE [16] = '{
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
        7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
        7'b1111111, 7'b1100111, 7'b1110111, 7'b1111100,
        7'b1011000, 7'b1011110, 7'b1111001, 7'b1110001
    };

endpackage

// File: columnSync.sv
// column input synchronizer
`timescale 1ns/1ps

module columnSync (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [keypadPkg::COLS-1:0] colAsync,
    output logic [keypadPkg::COLS-1:0] col
);

    // first stage may go metastable, second one settles it
    logic [keypadPkg::COLS-1:0] stage1;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stage1 <= '0;
            col <= '0;
        end else begin
            stage1 <= colAsync;
            col <= stage1;
        end
    end

endmodule

// File: keypadScanner.sv
// keypad row scanner
`timescale 1ns/1ps

module keypadScanner (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [keypadPkg::COLS-1:0] col,
    output logic [keypadPkg::ROWS-1:0] row,
    output logic                       keyActive,
    output keypadPkg::keyCode          keyCode
);

    typedef enum logic {
        SCANNING,
        HELD
    } scanState;

    scanState state;

    logic [keypadPkg::ROW_BITS-1:0] rowIdx;
    logic [keypadPkg::ROW_BITS-1:0] nextRow;
    logic [keypadPkg::DWELL_BITS-1:0] dwell;
    logic [keypadPkg::COL_BITS-1:0] heldCol;
    logic [keypadPkg::COL_BITS-1:0] hitCol;
    logic hit;

    // lowest set column has priority
    always_comb begin
        hit = 1'b0;
        hitCol = '0;
        for (int c = keypadPkg::COLS - 1; c >= 0; c--) begin
            if (col[c]) begin
                hit = 1'b1;
                hitCol = c[keypadPkg::COL_BITS-1:0];
            end
        end
    end

    assign nextRow = (rowIdx == keypadPkg::LAST_ROW) ? '0 : rowIdx + 1'b1;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= SCANNING;
            rowIdx <= '0;
            dwell <= '0;
            heldCol <= '0;
        end else begin
            case (state)
                SCANNING: begin
                    // columns sampled on the last dwell cycle only
                    if (dwell == keypadPkg::DWELL_LAST) begin
                        dwell <= '0;
                        if (hit) begin
                            state <= HELD;
                            heldCol <= hitCol;
                        end else begin
                            rowIdx <= nextRow;
                        end
                    end else begin
                        dwell <= dwell + 1'b1;
                    end
                end
                HELD: begin
                    // release resumes the scan at the following row
                    if (!col[heldCol]) begin
                        state <= SCANNING;
                        rowIdx <= nextRow;
                    end
                end
                default: begin
                    state <= SCANNING;
                end
            endcase
        end
    end

    // drive only the current row
    always_comb begin
        row = '0;
        row[rowIdx] = 1'b1;
    end

    assign keyActive = (state == HELD);
    assign keyCode = keypadPkg::KEY_MAP[rowIdx][heldCol];

    rowOneHot: assert property (@(posedge clk) disable iff (reset) $onehot(row));

endmodule

// File: keyDebouncer.sv
// key press debouncer
`timescale 1ns/1ps

module keyDebouncer (
    input  logic              clk,
    input  logic              reset,
    input  logic              keyActive,
    input  keypadPkg::keyCode keyCode,
    output logic              keyValid,
    output keypadPkg::keyCode newKey
);

    keypadPkg::keyCode lastCode;
    logic [keypadPkg::DEBOUNCE_BITS-1:0] count;
    logic accepted;
    logic stable;

    // same key as last cycle and still pressed
    assign stable = keyActive && (keyCode == lastCode);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count <= '0;
            accepted <= 1'b0;
        end else if (!keyActive) begin
            count <= '0;
            accepted <= 1'b0;
        end else if (keyCode != lastCode) begin
            // a new code restarts the count, this cycle is the first
            count <= 1;
        end else if (!accepted) begin
            count <= count + 1'b1;
            if (keyValid) begin
                accepted <= 1'b1;
            end
        end
    end

    // payload only, follows the scanner every cycle
    always_ff @(posedge clk) begin
        lastCode <= keyCode;
    end

    // one entry per press
    assign keyValid = stable && !accepted && (count == keypadPkg::DEBOUNCE_LAST);
    assign newKey = lastCode;

    validPulse: assert property (
        @(posedge clk) disable iff (reset)
        keyValid |=> !keyValid
    );

    // a valid key has been held through the whole window
    validNeedsHold: assert property (
        @(posedge clk) disable iff (reset)
        keyValid |-> keyActive && $past(keyActive, keypadPkg::DEBOUNCE_CYCLES - 1)
    );

endmodule

// File: digitDisplay.sv
// two-digit seven-segment display
`timescale 1ns/1ps

module digitDisplay (
    input  logic              clk,
    input  logic              reset,
    input  logic              keyValid,
    input  keypadPkg::keyCode newKey,
    output logic              anodeLeft,
    output logic              anodeRight,
    output keypadPkg::segments seg
);

    keypadPkg::keyCode leftDigit;
    keypadPkg::keyCode rightDigit;
    keypadPkg::keyCode shownDigit;

    // top bit selects the lit digit
    logic [keypadPkg::REFRESH_EXP:0] refreshCnt;

    // newest key enters on the right
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            leftDigit <= '0;
            rightDigit <= '0;
        end else if (keyValid) begin
            leftDigit <= rightDigit;
            rightDigit <= newKey;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            refreshCnt <= '0;
        end else begin
            refreshCnt <= refreshCnt + 1'b1;
        end
    end

    assign anodeLeft = refreshCnt[keypadPkg::REFRESH_EXP];
    assign anodeRight = ~refreshCnt[keypadPkg::REFRESH_EXP];

    assign shownDigit = anodeLeft ? leftDigit : rightDigit;

    // segments are active low on common-anode digits
    assign seg = ~keypadPkg::SEG_TABLE[shownDigit];

    anodeExclusive: assert property (
        @(posedge clk) disable iff (reset)
        $onehot({anodeLeft, anodeRight})
    );

endmodule

// File: keypadTop.sv
// keypad to display top level
`timescale 1ns/1ps

module keypadTop (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [keypadPkg::COLS-1:0] colAsync,
    output logic [keypadPkg::ROWS-1:0] row,
    output keypadPkg::segments         seg,
    output logic                       anodeLeft,
    output logic                       anodeRight
);

    logic [keypadPkg::COLS-1:0] col;
    logic keyActive;
    keypadPkg::keyCode keyCode;
    logic keyValid;
    keypadPkg::keyCode newKey;

    columnSync colSync (
        .clk      (clk),
        .reset    (reset),
        .colAsync (colAsync),
        .col      (col)
    );

    keypadScanner scanner (
        .clk       (clk),
        .reset     (reset),
        .col       (col),
        .row       (row),
        .keyActive (keyActive),
        .keyCode   (keyCode)
    );

    keyDebouncer debouncer (
        .clk       (clk),
        .reset     (reset),
        .keyActive (keyActive),
        .keyCode   (keyCode),
        .keyValid  (keyValid),
        .newKey    (newKey)
    );

    digitDisplay display (
        .clk        (clk),
        .reset      (reset),
        .keyValid   (keyValid),
        .newKey     (newKey),
        .anodeLeft  (anodeLeft),
        .anodeRight (anodeRight),
        .seg        (seg)
    );

endmodule

// File: tbClock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 10 cycles, released just after an edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: keypadTb.sv
// keypad testbench
`timescale 1ns/1ps

module keypadTb;

    localparam int SETTLE_CYCLES = 100;
    localparam int ACCEPT_HOLD = 60;
    localparam int TAP_HOLD = 3;
    localparam int IDLE_CYCLES = 700;
    localparam int GAP_CYCLES = 600;
    localparam int HOLD_NORMAL = 200;
    localparam int HOLD_LONG = 600;
    localparam int HOLD_RANDOM = 80;
    localparam int PLANNED_CYCLES = 20 + IDLE_CYCLES + 2 * (HOLD_NORMAL + GAP_CYCLES)
        + (keypadPkg::ROWS * keypadPkg::ROW_DWELL + TAP_HOLD + GAP_CYCLES)
        + 2 * (HOLD_LONG + GAP_CYCLES) + 16 * (HOLD_RANDOM + GAP_CYCLES);
    localparam int TIMEOUT_CYCLES = PLANNED_CYCLES + PLANNED_CYCLES / 8;
    localparam logic [31:0] LFSR_SEED = 32'h3362f744;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk;
    logic reset;
    logic [keypadPkg::COLS-1:0] colAsync;
    logic [keypadPkg::ROWS-1:0] row;
    keypadPkg::segments seg;
    logic anodeLeft;
    logic anodeRight;

    // keypad model and expected display
    logic pressed;
    int pressRow;
    int pressCol;
    keypadPkg::keyCode expLeft;
    keypadPkg::keyCode expRight;
    keypadPkg::keyCode shownExp;
    logic [31:0] lfsrState;
    int keyOrder [16];
    int cycleCount = 0;
    int lastChange = 0;
    int resetEnd = 0;
    int runLen = 0;
    logic [keypadPkg::ROWS-1:0] prevRow;
    logic settled;
    logic expectLeftOn;

    tbClock clockGen (.clk(clk), .reset(reset));

    keypadTop uut (
        .clk        (clk),
        .reset      (reset),
        .colAsync   (colAsync),
        .row        (row),
        .seg        (seg),
        .anodeLeft  (anodeLeft),
        .anodeRight (anodeRight)
    );

    // a pressed key connects its row to its column
    always_comb begin
        colAsync = '0;
        if (pressed && row[pressRow]) begin
            colAsync[pressCol] = 1'b1;
        end
    end

    assign shownExp = expectLeftOn ? expLeft : expRight;
    assign settled = (cycleCount - lastChange) >= SETTLE_CYCLES;
    assign expectLeftOn = (((cycleCount - resetEnd) >> keypadPkg::REFRESH_EXP) % 2) == 1;

    // how long the previous row was driven
    always @(posedge clk) begin
        prevRow <= row;
        runLen <= (row != prevRow) ? 1 : runLen + 1;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            reportFailure($sformatf("timeout after %0d cycles, stimulus never finished", cycleCount));
        end
    end

    segCheck: assert property (@(posedge clk) disable iff (reset)
        settled |-> seg == ~keypadPkg::SEG_TABLE[shownExp])
        else reportFailure($sformatf("Mismatch at %0t: expected digit %h, seen digit %s",
            $time, $sampled(shownExp), digitName($sampled(seg))));

    anodeTiming: assert property (@(posedge clk) disable iff (reset) anodeLeft == expectLeftOn)
        else reportFailure($sformatf("Mismatch at %0t: anodeLeft is %b, expected %b",
            $time, $sampled(anodeLeft), $sampled(expectLeftOn)));

    anodeOneHot: assert property (@(posedge clk) disable iff (reset) anodeLeft != anodeRight)
        else reportFailure("both anodes or neither anode is on");

    rowOneHot: assert property (@(posedge clk) disable iff (reset) $onehot(row))
        else reportFailure("row output is not one-hot");

    // idle scan rotates one row up after a full dwell
    scanStep: assert property (@(posedge clk) disable iff (reset)
        !pressed && settled && row != prevRow
            |-> row == {prevRow[keypadPkg::ROWS-2:0], prevRow[keypadPkg::ROWS-1]}
                && runLen == keypadPkg::ROW_DWELL)
        else reportFailure($sformatf("Mismatch at %0t: row went from %b to %b after %0d cycles",
            $time, $sampled(prevRow), $sampled(row), $sampled(runLen)));

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    function automatic string digitName(input keypadPkg::segments pattern);
        for (int d = 0; d < 16; d++) begin
            if (pattern == ~keypadPkg::SEG_TABLE[d]) begin
                return $sformatf("%h", d[3:0]);
            end
        end
        return "none";
    endfunction

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic takeBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    // random key order with one swap per position
    task automatic shuffleKeys();
        int pick;
        int tmp;
        for (int i = 15; i > 0; i--) begin
            takeBits(4, pick);
            pick = pick % (i + 1);
            tmp = keyOrder[i];
            keyOrder[i] = keyOrder[pick];
            keyOrder[pick] = tmp;
        end
    endtask

    task automatic waitCycles(input int count);
        repeat (count) @(posedge clk);
        #1;
    endtask

    // returns just after the scanner moves onto the given row
    task automatic waitRowStart(input int r);
        logic wasDriven;
        wasDriven = row[r];
        waitCycles(1);
        while (wasDriven || !row[r]) begin
            wasDriven = row[r];
            waitCycles(1);
        end
    endtask

    // position is row * COLS + column
    task automatic pressKey(input int position, input int hold, input int gap);
        if (hold >= ACCEPT_HOLD) begin
            expLeft = expRight;
            expRight = keypadPkg::KEY_MAP[position / keypadPkg::COLS][position % keypadPkg::COLS];
        end
        pressRow = position / keypadPkg::COLS;
        pressCol = position % keypadPkg::COLS;
        pressed = 1'b1;
        lastChange = cycleCount;
        waitCycles(hold);
        pressed = 1'b0;
        lastChange = cycleCount;
        waitCycles(gap);
    endtask

    initial begin
        pressed = 1'b0;
        pressRow = 0;
        pressCol = 0;
        expLeft = '0;
        expRight = '0;
        lfsrState = LFSR_SEED;
        for (int k = 0; k < 16; k++) begin
            keyOrder[k] = k;
        end
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        resetEnd = cycleCount;
        lastChange = cycleCount;
        // zeros on both digits during a free scan
        waitCycles(IDLE_CYCLES);
        // keys 1 then 2
        pressKey(12, HOLD_NORMAL, GAP_CYCLES);
        pressKey(13, HOLD_NORMAL, GAP_CYCLES);
        // a tap on 5 as its row comes up is seen by the scan but must not enter
        waitRowStart(9 / keypadPkg::COLS);
        pressKey(9, TAP_HOLD, GAP_CYCLES);
        // long holds on 9 enter once per press
        pressKey(6, HOLD_LONG, GAP_CYCLES);
        pressKey(6, HOLD_LONG, GAP_CYCLES);
        shuffleKeys();
        for (int k = 0; k < 16; k++) begin
            pressKey(keyOrder[k], HOLD_RANDOM, GAP_CYCLES);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// File: project.f
keypadPkg.sv
columnSync.sv
keypadScanner.sv
keyDebouncer.sv
digitDisplay.sv
keypadTop.sv
tbClock.sv
keypadTb.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module keypadTb -f project.f \
    -o keypadSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/keypadSim > sim.log 2>&1 || true
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log \
    && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
